// ==== cache_pkg.sv ====
package cache_pkg;

    // cache geometry
    localparam int s_word   = 256;   // line width in bits
    localparam int s_mask   = 32;    // one enable per byte lane
    localparam int s_offset = 5;
    localparam int s_index  = 4;
    localparam int s_tag    = 23;    // 32 - index - offset
    localparam int s_wayidx = 2;
    localparam int num_ways = 4;
    localparam int num_sets = 16;

    // target way for data and dirty writes
    typedef enum logic {
        way_hit    = 1'b0,
        way_victim = 1'b1
    } way_sel_t;

    // source of a data array write
    typedef enum logic {
        data_cpu = 1'b0,   // cpu word, cpu byte enables
        data_mem = 1'b1    // memory line, all lanes
    } data_sel_t;

    // tag field of the physical address
    typedef enum logic {
        pmad_req    = 1'b0,
        pmad_victim = 1'b1
    } pmad_sel_t;

    // strobes and selects from the controller
    typedef struct packed {
        logic      ld_valid;
        logic      ld_dirty;
        logic      ld_tag;
        logic      ld_data;
        logic      ld_plru;
        logic      dirty_val;
        way_sel_t  dirty_wsel;
        way_sel_t  data_wsel;
        data_sel_t data_sel;
        pmad_sel_t pmad_sel;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;   // victim is valid and modified
    } cache_stat_t;

endpackage

// ==== line_array.sv ====
`timescale 1ns/1ps

// one word per set, written in lanes of width/mask_width bits
module line_array #(
    parameter int width      = 256,
    parameter int mask_width = width / 8
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [mask_width-1:0]         wmask,
    input  logic [cache_pkg::s_index-1:0] index,
    input  logic [width-1:0]              din,
    output logic [width-1:0]              dout
);

    localparam int lane = width / mask_width;

    logic [width-1:0] mem [cache_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < mask_width; i++) begin
                if (wmask[i]) begin
                    mem[index][i*lane +: lane] <= din[i*lane +: lane];
                end
            end
        end
        dout <= mem[index];   // old contents on a write cycle
    end

endmodule

// ==== bit_array.sv ====
`timescale 1ns/1ps

module bit_array (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [cache_pkg::s_index-1:0] index,
    input  logic                          din,
    output logic                          dout
);

    logic [cache_pkg::num_sets-1:0] bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            bits <= '0;
            dout <= 1'b0;
        end else begin
            if (we) bits[index] <= din;
            dout <= bits[index];   // registered read, no bypass
        end
    end

endmodule

// ==== plru_tree.sv ====
`timescale 1ns/1ps

// tree pseudo-LRU, node 1 is the root and node n has children 2n and 2n+1
module plru_tree (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cache_pkg::s_index-1:0]  index,
    input  logic                           touch,
    input  logic [cache_pkg::s_wayidx-1:0] way,
    output logic [cache_pkg::s_wayidx-1:0] victim
);

    logic [cache_pkg::num_ways-1:1] tree [cache_pkg::num_sets];
    logic [cache_pkg::num_ways-1:1] cur;
    logic [cache_pkg::num_ways-1:1] upd;

    assign cur = tree[index];

    // every node on the path of the used way takes that way's bit for its level
    always_comb begin : path_update
        logic [cache_pkg::s_wayidx:0] node;
        upd = cur;
        for (int k = 0; k < cache_pkg::s_wayidx; k++) begin
            node = {1'b1, way} >> (k + 1);
            upd[node] = way[k];
        end
    end

    // walk from the root, always against the stored direction
    always_comb begin : victim_walk
        logic [cache_pkg::s_wayidx:0] node;
        logic                         dir;
        node   = 1;
        victim = '0;
        for (int n = cache_pkg::s_wayidx - 1; n >= 0; n--) begin
            dir       = ~cur[node];
            victim[n] = dir;
            node      = {node[cache_pkg::s_wayidx-1:0], dir};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                tree[s] <= '0;   // all zero, victim is the last way
            end
        end else if (touch) begin
            tree[index] <= upd;
        end
    end

    a_victim_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(index) |-> !$isunknown(victim)
    ) else $error("plru victim unknown for set %0d", index);

endmodule

// ==== cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [31:0]                   mem_address,
    input  logic [cache_pkg::s_mask-1:0]  mem_byte_enable,
    input  logic [cache_pkg::s_word-1:0]  mem_wdata,
    output logic [cache_pkg::s_word-1:0]  mem_rdata,

    output logic [31:0]                   pmem_address,
    output logic [cache_pkg::s_word-1:0]  pmem_wdata,
    input  logic [cache_pkg::s_word-1:0]  pmem_rdata,

    input  cache_pkg::cache_ctrl_t        ctrl,
    output cache_pkg::cache_stat_t        stat
);

    logic [cache_pkg::s_tag-1:0]    addr_tag;
    logic [cache_pkg::s_index-1:0]  addr_index;

    logic [cache_pkg::s_word-1:0]   data_q [cache_pkg::num_ways];
    logic [cache_pkg::s_tag-1:0]    tag_q  [cache_pkg::num_ways];
    logic [cache_pkg::num_ways-1:0] valid_q;
    logic [cache_pkg::num_ways-1:0] dirty_q;

    logic [cache_pkg::num_ways-1:0] hit_mask;
    logic [cache_pkg::num_ways-1:0] victim_mask;
    logic [cache_pkg::num_ways-1:0] data_wmask;
    logic [cache_pkg::num_ways-1:0] dirty_wmask;
    logic [cache_pkg::s_wayidx-1:0] hit_way;
    logic [cache_pkg::s_wayidx-1:0] victim_way;
    logic [cache_pkg::s_word-1:0]   line_in;
    logic [cache_pkg::s_mask-1:0]   lane_en;
    logic [cache_pkg::s_tag-1:0]    pmem_tag;

    assign addr_tag   = mem_address[31 -: cache_pkg::s_tag];
    assign addr_index = mem_address[cache_pkg::s_offset +: cache_pkg::s_index];

    // a way hits only when it holds a valid line with the same tag
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            hit_mask[w] = valid_q[w] & (tag_q[w] == addr_tag);
            if (hit_mask[w]) hit_way = w[cache_pkg::s_wayidx-1:0];
        end
    end

    assign victim_mask = {{(cache_pkg::num_ways - 1){1'b0}}, 1'b1} << victim_way;

    assign stat.hit          = |hit_mask;
    assign stat.victim_dirty = valid_q[victim_way] & dirty_q[victim_way];

    assign data_wmask  = (ctrl.data_wsel == cache_pkg::way_victim) ? victim_mask : hit_mask;
    assign dirty_wmask = (ctrl.dirty_wsel == cache_pkg::way_victim) ? victim_mask : hit_mask;

    // fill takes the whole line, a cpu store only its enabled bytes
    assign line_in = (ctrl.data_sel == cache_pkg::data_mem) ? pmem_rdata : mem_wdata;
    assign lane_en = (ctrl.data_sel == cache_pkg::data_mem) ? '1 : mem_byte_enable;

    assign mem_rdata  = data_q[hit_way];
    assign pmem_wdata = data_q[victim_way];   // line to write back

    assign pmem_tag     = (ctrl.pmad_sel == cache_pkg::pmad_victim) ? tag_q[victim_way]
                                                                     : addr_tag;
    assign pmem_address = {pmem_tag, addr_index, {cache_pkg::s_offset{1'b0}}};

    for (genvar i = 0; i < cache_pkg::num_ways; i++) begin : g_way
        line_array #(
            .width      (cache_pkg::s_word),
            .mask_width (cache_pkg::s_mask)
        ) data_array (
            .clk   (clk),
            .we    (ctrl.ld_data & data_wmask[i]),
            .wmask (lane_en),
            .index (addr_index),
            .din   (line_in),
            .dout  (data_q[i])
        );

        line_array #(
            .width      (cache_pkg::s_tag),
            .mask_width (1)
        ) tag_array (
            .clk   (clk),
            .we    (ctrl.ld_tag & victim_mask[i]),
            .wmask (1'b1),
            .index (addr_index),
            .din   (addr_tag),
            .dout  (tag_q[i])
        );

        bit_array valid_array (
            .clk   (clk),
            .rst   (rst),
            .we    (ctrl.ld_valid & victim_mask[i]),
            .index (addr_index),
            .din   (1'b1),   // only fills set valid
            .dout  (valid_q[i])
        );

        bit_array dirty_array (
            .clk   (clk),
            .rst   (rst),
            .we    (ctrl.ld_dirty & dirty_wmask[i]),
            .index (addr_index),
            .din   (ctrl.dirty_val),
            .dout  (dirty_q[i])
        );
    end

    plru_tree plru0 (
        .clk    (clk),
        .rst    (rst),
        .index  (addr_index),
        .touch  (ctrl.ld_plru),
        .way    (hit_way),
        .victim (victim_way)
    );

    // fills only happen on a miss, so a set never holds one tag twice
    a_single_hit: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(mem_address) |-> $onehot0(hit_mask)
    ) else $error("more than one way hits, mask %b", hit_mask);

endmodule

// ==== cache_control.sv ====
`timescale 1ns/1ps

module cache_control (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   mem_read,
    input  logic                   mem_write,
    output logic                   mem_resp,

    output logic                   pmem_read,
    output logic                   pmem_write,
    input  logic                   pmem_resp,

    input  cache_pkg::cache_stat_t stat,
    output cache_pkg::cache_ctrl_t ctrl
);

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_allocate,
        st_settle
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) state <= st_idle;
        else     state <= state_next;
    end

    always_comb begin
        ctrl       = '0;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        state_next = state;

        case (state)
            st_idle: begin
                // arrays need one cycle on the new index before compare
                if (mem_read | mem_write) state_next = st_settle;
            end

            st_settle: state_next = st_compare;

            st_compare: begin
                if (stat.hit) begin
                    mem_resp     = 1'b1;
                    ctrl.ld_plru = 1'b1;
                    if (mem_write) begin
                        ctrl.ld_data    = 1'b1;
                        ctrl.data_sel   = cache_pkg::data_cpu;
                        ctrl.data_wsel  = cache_pkg::way_hit;
                        ctrl.ld_dirty   = 1'b1;
                        ctrl.dirty_val  = 1'b1;
                        ctrl.dirty_wsel = cache_pkg::way_hit;
                    end
                    state_next = st_idle;
                end else if (stat.victim_dirty) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_allocate;
                end
            end

            st_writeback: begin
                pmem_write    = 1'b1;
                ctrl.pmad_sel = cache_pkg::pmad_victim;   // address of the old line
                if (pmem_resp) state_next = st_allocate;
            end

            st_allocate: begin
                pmem_read     = 1'b1;
                ctrl.pmad_sel = cache_pkg::pmad_req;
                if (pmem_resp) begin
                    ctrl.ld_data    = 1'b1;
                    ctrl.data_sel   = cache_pkg::data_mem;
                    ctrl.data_wsel  = cache_pkg::way_victim;
                    ctrl.ld_tag     = 1'b1;
                    ctrl.ld_valid   = 1'b1;
                    ctrl.ld_dirty   = 1'b1;   // fresh line is clean
                    ctrl.dirty_val  = 1'b0;
                    ctrl.dirty_wsel = cache_pkg::way_victim;
                    state_next      = st_settle;
                end
            end

            default: state_next = st_idle;
        endcase
    end

    a_resp_no_pmem: assert property (
        @(posedge clk) disable iff (rst)
        mem_resp |-> !(pmem_read || pmem_write)
    ) else $error("mem_resp while a memory request is open");

    a_pmem_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write)
    ) else $error("pmem_read and pmem_write both high");

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                         clk,
    input  logic                         rst,

    // cpu side
    input  logic [31:0]                  mem_address,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic [cache_pkg::s_mask-1:0] mem_byte_enable,
    input  logic [cache_pkg::s_word-1:0] mem_wdata,
    output logic [cache_pkg::s_word-1:0] mem_rdata,
    output logic                         mem_resp,

    // physical memory side
    output logic [31:0]                  pmem_address,
    output logic                         pmem_read,
    output logic                         pmem_write,
    output logic [cache_pkg::s_word-1:0] pmem_wdata,
    input  logic [cache_pkg::s_word-1:0] pmem_rdata,
    input  logic                         pmem_resp
);

    cache_pkg::cache_ctrl_t ctrl;
    cache_pkg::cache_stat_t stat;

    cache_control control0 (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .pmem_resp  (pmem_resp),
        .stat       (stat),
        .ctrl       (ctrl)
    );

    cache_datapath datapath0 (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .ctrl            (ctrl),
        .stat            (stat)
    );

endmodule

// ==== phys_mem_model.sv ====
`timescale 1ns/1ps

// line memory behind the cache, each request answered after 1 to 4 cycles
module phys_mem_model (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [31:0]                  pmem_address,
    input  logic                         pmem_read,
    input  logic                         pmem_write,
    input  logic [cache_pkg::s_word-1:0] pmem_wdata,
    output logic [cache_pkg::s_word-1:0] pmem_rdata,
    output logic                         pmem_resp
);

    logic [cache_pkg::s_word-1:0] lines [logic [31:0]];   // written-back lines only
    logic                         busy;
    int                           wait_cnt;

    // byte i of a line comes from address a + i
    function automatic logic [cache_pkg::s_word-1:0] hash_line(input logic [31:0] a);
        logic [cache_pkg::s_word-1:0] l;
        logic [31:0]                  h;
        for (int i = 0; i < cache_pkg::s_mask; i++) begin
            h = ((a + i) ^ 32'h5bd1_e995) * 32'h9e37_79b1;
            l[i*8 +: 8] = h[31:24] ^ h[15:8];
        end
        return l;
    endfunction

    initial begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        busy       = 1'b0;
        wait_cnt   = 0;
    end

    always @(negedge clk) begin
        if (rst) begin
            pmem_resp <= 1'b0;
            busy      <= 1'b0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;   // one cycle pulse
            busy      <= 1'b0;
        end else if (pmem_read || pmem_write) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= $urandom_range(3, 0);
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                pmem_resp <= 1'b1;
                if (pmem_write) lines[pmem_address] = pmem_wdata;
                else if (lines.exists(pmem_address)) pmem_rdata <= lines[pmem_address];
                else pmem_rdata <= hash_line(pmem_address);
            end
        end
    end

endmodule

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    localparam int num_req    = 400;
    localparam int max_cycles = num_req * (2 + 2 * 6) + 400;

    typedef struct packed {
        logic                         write;
        logic [31:0]                  addr;
        logic [cache_pkg::s_mask-1:0] be;
        logic [cache_pkg::s_word-1:0] data;
    } req_t;

    logic                         clk;
    logic                         rst;
    logic [31:0]                  mem_address;
    logic                         mem_read;
    logic                         mem_write;
    logic [cache_pkg::s_mask-1:0] mem_byte_enable;
    logic [cache_pkg::s_word-1:0] mem_wdata;
    logic [cache_pkg::s_word-1:0] mem_rdata;
    logic                         mem_resp;
    logic [31:0]                  pmem_address;
    logic                         pmem_read;
    logic                         pmem_write;
    logic [cache_pkg::s_word-1:0] pmem_wdata;
    logic [cache_pkg::s_word-1:0] pmem_rdata;
    logic                         pmem_resp;

    // shadow of the cache state, used to predict hits and victims
    logic [cache_pkg::s_tag-1:0] sh_tag   [cache_pkg::num_sets][cache_pkg::num_ways];
    bit                          sh_valid [cache_pkg::num_sets][cache_pkg::num_ways];
    bit                          sh_dirty [cache_pkg::num_sets][cache_pkg::num_ways];
    bit                          sh_root  [cache_pkg::num_sets];
    bit                          sh_child [cache_pkg::num_sets][2];

    logic [7:0] ref_mem [logic [31:0]];   // bytes written by the cpu
    bit         partial_line [logic [31:0]];
    bit         reloaded [logic [31:0]];   // partial line evicted at least once
    logic [cache_pkg::s_tag-1:0]   tag_pool [6];
    logic [cache_pkg::s_index-1:0] set_pool [3];
    int    checks [5];
    int    errors [5];
    string names [5];
    int    reload_checks;
    int    cycle_count;

    cache_top dut0 (.*);
    phys_mem_model mem0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [cache_pkg::s_word-1:0] ref_line(input logic [31:0] a);
        logic [cache_pkg::s_word-1:0] l;
        for (int i = 0; i < cache_pkg::s_mask; i++) begin
            l[i*8 +: 8] = ref_mem.exists(a + i) ? ref_mem[a + i] : fill_byte(a + i);
        end
        return l;
    endfunction

    // walk against the stored node at each level
    function automatic logic [1:0] victim_of(input logic [cache_pkg::s_index-1:0] set);
        bit v1;
        v1 = ~sh_root[set];
        return {v1, ~sh_child[set][v1]};
    endfunction

    task automatic compare_value(input int b, input string name,
                                 input logic [255:0] exp, input logic [255:0] got);
        checks[b]++;
        assert (got === exp) else begin
            $display("** Error: %s expected %0h got %0h", name, exp, got);
            errors[b]++;
        end
    endtask

    task automatic require_true(input int b, input bit ok, input string what);
        checks[b]++;
        assert (ok) else begin
            $display("failure: %s", what);
            errors[b]++;
        end
    endtask

    task automatic run_request(input req_t r);
        logic [cache_pkg::s_index-1:0] set;
        logic [cache_pkg::s_tag-1:0]   tag;
        logic [31:0]                   line;
        logic [31:0]                   vline;
        logic [31:0]                   first_addr;
        logic [cache_pkg::s_word-1:0]  first_data;
        logic [cache_pkg::s_word-1:0]  exp;
        logic [1:0]                    way;
        int                            hw;
        int                            lat;
        int                            n_rd;
        bit                            vdirty;
        bit                            first_seen;
        bit                            first_wr;
        bit                            any_wr;
        bit                            prev_rd;
        set   = r.addr[cache_pkg::s_offset +: cache_pkg::s_index];
        tag   = r.addr[31 -: cache_pkg::s_tag];
        line  = {r.addr[31:5], 5'b0};
        hw    = -1;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (sh_valid[set][w] && sh_tag[set][w] == tag) hw = w;
        end
        way    = (hw >= 0) ? 2'(hw) : victim_of(set);
        vdirty = (hw < 0) && sh_valid[set][way] && sh_dirty[set][way];
        vline  = {sh_tag[set][way], set, 5'b0};

        mem_address     = r.addr;
        mem_read        = !r.write;
        mem_write       = r.write;
        mem_byte_enable = r.be;
        mem_wdata       = r.data;
        lat        = 0;
        n_rd       = 0;
        first_seen = 1'b0;
        first_wr   = 1'b0;
        any_wr     = 1'b0;
        prev_rd    = 1'b0;
        do begin
            @(negedge clk);
            lat++;
            if ((pmem_read || pmem_write) && !first_seen) begin
                first_seen = 1'b1;
                first_wr   = pmem_write;
                first_addr = pmem_address;
                first_data = pmem_wdata;
            end
            if (pmem_read && !prev_rd) n_rd++;
            if (pmem_write) any_wr = 1'b1;
            prev_rd = pmem_read;
        end while (!mem_resp);

        if (hw >= 0) begin
            require_true(1, lat == 2 && !first_seen,
                         $sformatf("hit on %h took %0d cycles or went to memory", r.addr, lat));
        end else if (vdirty) begin
            require_true(2, first_wr && n_rd == 1, "dirty miss did not write back, then read");
            compare_value(2, "pmem_address", 256'(vline), 256'(first_addr));
            compare_value(2, "pmem_wdata", ref_line(vline), first_data);
        end else begin
            require_true(3, !any_wr && n_rd == 1, "clean miss wrote back or read more than once");
            compare_value(3, "pmem_address", 256'(line), 256'(first_addr));
        end
        if (!r.write) begin
            exp = ref_line(line);
            compare_value(0, "mem_rdata", exp, mem_rdata);
            if (partial_line.exists(line)) begin
                compare_value(4, "mem_rdata", exp, mem_rdata);
                if (reloaded.exists(line)) reload_checks++;
            end
        end

        if (hw < 0) begin
            if (sh_valid[set][way] && partial_line.exists(vline)) reloaded[vline] = 1'b1;
            sh_tag[set][way]   = tag;
            sh_valid[set][way] = 1'b1;
            sh_dirty[set][way] = 1'b0;
        end
        sh_root[set]          = way[1];   // path of the used way
        sh_child[set][way[1]] = way[0];
        if (r.write) begin
            sh_dirty[set][way] = 1'b1;
            for (int i = 0; i < cache_pkg::s_mask; i++) begin
                if (r.be[i]) ref_mem[line + i] = r.data[i*8 +: 8];
            end
            if (r.be != '1) partial_line[line] = 1'b1;
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: requests still running after %0d cycles", max_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        req_t r;
        int   tc;
        int   te;
        void'($urandom(32'hf766_d397));
        rst             = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        names = '{"read data", "hit latency", "dirty victim", "clean miss", "byte enables"};
        for (int i = 0; i < 6; i++) begin
            tag_pool[i] = {20'($urandom()), 3'(i)};   // distinct by their low bits
        end
        set_pool[0] = 4'($urandom());
        set_pool[1] = set_pool[0] + 4'd5;
        set_pool[2] = set_pool[0] + 4'd10;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < num_req; i++) begin
            r.write = 1'($urandom_range(1, 0));
            r.addr  = {tag_pool[$urandom_range(5, 0)], set_pool[$urandom_range(2, 0)],
                       5'($urandom_range(31, 0))};
            r.be    = ($urandom_range(3, 0) == 0) ? '1 : $urandom();
            for (int k = 0; k < 8; k++) r.data[k*32 +: 32] = $urandom();
            if ($urandom_range(7, 0) == 0) begin   // an idle cycle now and then
                @(negedge clk);
                mem_read  = 1'b0;
                mem_write = 1'b0;
            end
            @(negedge clk);
            run_request(r);
        end
        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;

        require_true(4, reload_checks > 0, "no partial line was read back after an eviction");
        tc = 0;
        te = 0;
        for (int b = 0; b < 5; b++) begin
            $display("%s: %0d checks, %0d errors", names[b], checks[b], errors[b]);
            tc += checks[b];
            te += errors[b];
        end
        $display("total: %0d checks, %0d errors", tc, te);
        if (te == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
cache_pkg.sv
line_array.sv
bit_array.sv
plru_tree.sv
cache_datapath.sv
cache_control.sv
cache_top.sv
phys_mem_model.sv
cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module cache_tb \
    -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "Test completed successfully" sim.log \
    || { echo "simulation failed"; exit 1; }
